// File: edge_pkg.sv
`default_nettype none

package edge_pkg;

    // ------------------------------
    // bus and word widths
    // ------------------------------
    localparam int BYTE_W = 8;              // sensor data bus
    localparam int PIX_W  = 16;             // one rgb565 pixel
    localparam int LUMA_W = 7;              // r+g+b, at most 31+63+31 = 125
    localparam int LB_W   = PIX_W + LUMA_W; // line buffer word {pixel, luma}

    // magnitude msbs that mark a strong edge
    localparam int EDGE_SEL_BITS = 2;

    // ------------------------------
    // payload types
    // ------------------------------
    typedef struct packed {
        logic [4:0] r;                      // red in the msbs
        logic [5:0] g;                      // green in the middle
        logic [4:0] b;                      // blue in the lsbs
    } pixel_t;

    typedef logic [LUMA_W-1:0] luma_t;      // luma sum or edge magnitude

endpackage

`default_nettype wire

// File: cam_byte_packer.sv
`default_nettype none

module cam_byte_packer import edge_pkg::*; #(
    parameter int LINE_LEN = 480            // active pixels per line
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              vsync_i,     // frame restart
    input  wire logic              cam_href_i,  // line valid from sensor
    input  wire logic [BYTE_W-1:0] cam_data_i,  // high byte first
    output logic                   pix_de_o,
    output logic                   pix_eol_o,   // one pulse per line end
    output pixel_t                 pix_data_o,
    output luma_t                  pix_luma_o
);

    localparam int CNT_W = $clog2(LINE_LEN + 1);

    logic              href_d;              // href one cycle back
    logic              phase_q;             // high byte is held
    logic [BYTE_W-1:0] hi_byte_q;
    logic [CNT_W-1:0]  pix_cnt;             // pixels sent this line
    logic              href_fall;
    logic              pair_done;
    logic              pix_keep;            // still inside LINE_LEN
    pixel_t            pair_pix;
    luma_t             pair_luma;

    assign href_fall = href_d && !cam_href_i;
    assign pair_done = cam_href_i && !vsync_i && phase_q; // low byte arriving
    assign pix_keep  = pix_cnt < CNT_W'(LINE_LEN);
    assign pair_pix  = {hi_byte_q, cam_data_i};
    assign pair_luma = LUMA_W'(pair_pix.r) + LUMA_W'(pair_pix.g) + LUMA_W'(pair_pix.b);

    // ------------------------------
    // pairing and line control
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            href_d    <= 1'b0;
            phase_q   <= 1'b0;
            pix_cnt   <= '0;
            pix_de_o  <= 1'b0;
            pix_eol_o <= 1'b0;
        end else begin
            href_d    <= cam_href_i;
            pix_eol_o <= href_fall && !vsync_i;   // line end marker
            pix_de_o  <= pair_done && pix_keep;   // drop beats past LINE_LEN
            if (vsync_i || !cam_href_i) begin
                phase_q <= 1'b0;                  // odd byte is lost here
                pix_cnt <= '0;
            end else begin
                phase_q <= !phase_q;
                if (phase_q && pix_keep) begin
                    pix_cnt <= pix_cnt + CNT_W'(1);
                end
            end
        end
    end

    // byte hold and pixel payload
    always_ff @(posedge clk) begin
        if (cam_href_i && !phase_q) begin
            hi_byte_q <= cam_data_i;              // first byte of pair
        end
        if (pair_done) begin
            pix_data_o <= pair_pix;
            pix_luma_o <= pair_luma;              // zero-extended r+g+b
        end
    end

endmodule

`default_nettype wire

// File: line_buffer.sv
`default_nettype none

module line_buffer import edge_pkg::*; #(
    parameter int LINE_LEN = 480            // words per row memory
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        vsync_i,
    input  wire logic                        pix_de_i,
    input  wire logic                        pix_eol_i,
    input  wire pixel_t                      pix_data_i,
    input  wire luma_t                       pix_luma_i,
    output logic                             col_de_o,
    output logic [LB_W-1:0]                  col_top_o,   // two rows back
    output logic [LB_W-1:0]                  col_mid_o,   // one row back
    output logic [LB_W-1:0]                  col_bot_o,   // current beat
    output logic [$clog2(LINE_LEN)-1:0]      col_idx_o
);

    localparam int COL_W = $clog2(LINE_LEN);

    // ------------------------------
    // storage
    // ------------------------------
    logic [LB_W-1:0]  row_mem_mid [LINE_LEN];   // previous row
    logic [LB_W-1:0]  row_mem_top [LINE_LEN];   // row before that
    logic [COL_W-1:0] col_cnt;                  // write/read address
    logic [1:0]       row_cnt;                  // stored rows, stops at 2
    logic             rows_full;
    logic             col_last;
    logic [LB_W-1:0]  new_word;

    assign new_word  = {pix_data_i, pix_luma_i};     // pixel over luma
    assign rows_full = (row_cnt == 2'd2);
    assign col_last  = (col_cnt == COL_W'(LINE_LEN - 1));

    // ------------------------------
    // column and row counters
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            col_de_o <= 1'b0;
        end else begin
            col_de_o <= pix_de_i && rows_full && !vsync_i; // third row onward
            if (vsync_i) begin
                col_cnt <= '0;                  // new frame
                row_cnt <= '0;
            end else if (pix_eol_i) begin
                col_cnt <= '0;
                if (!rows_full) begin
                    row_cnt <= row_cnt + 2'd1;
                end
            end else if (pix_de_i && !col_last) begin
                col_cnt <= col_cnt + COL_W'(1);
            end
        end
    end

    // row memories and column output
    always_ff @(posedge clk) begin
        if (pix_de_i) begin
            row_mem_mid[col_cnt] <= new_word;               // becomes mid row
            row_mem_top[col_cnt] <= row_mem_mid[col_cnt];   // mid ages to top
            col_top_o            <= row_mem_top[col_cnt];   // old words read
            col_mid_o            <= row_mem_mid[col_cnt];
            col_bot_o            <= new_word;
            col_idx_o            <= col_cnt;
        end
    end

endmodule

`default_nettype wire

// File: edge_filter3x3.sv
`default_nettype none

module edge_filter3x3 import edge_pkg::*; #(
    parameter int LINE_LEN = 480            // sizes the column index
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        vsync_i,
    input  wire logic                        col_de_i,
    input  wire logic [LB_W-1:0]             col_top_i,
    input  wire logic [LB_W-1:0]             col_mid_i,
    input  wire logic [LB_W-1:0]             col_bot_i,
    input  wire logic [$clog2(LINE_LEN)-1:0] col_idx_i,
    output logic                             pix_de_o,
    output pixel_t                           pix_o
);

    localparam int COL_W  = $clog2(LINE_LEN);
    localparam int SUM_W  = LUMA_W + 2;     // 1-2-1 sum, max 500
    localparam int GRAD_W = SUM_W + 1;      // signed difference

    // 1-2-1 weighted sum of three lumas
    function automatic logic [SUM_W-1:0] wsum(input luma_t a, input luma_t b, input luma_t c);
        wsum = SUM_W'(a) + SUM_W'({b, 1'b0}) + SUM_W'(c);
    endfunction

    // ------------------------------
    // incoming column split
    // ------------------------------
    luma_t  top_luma;                       // right column of window
    luma_t  mid_luma;
    luma_t  bot_luma;
    pixel_t mid_pix;

    assign top_luma = col_top_i[LUMA_W-1:0];
    assign mid_luma = col_mid_i[LUMA_W-1:0];
    assign bot_luma = col_bot_i[LUMA_W-1:0];
    assign mid_pix  = col_mid_i[LB_W-1:LUMA_W];

    luma_t  l_top;                          // left column
    luma_t  l_mid;
    luma_t  l_bot;
    luma_t  m_top;                          // middle column
    luma_t  m_mid;
    luma_t  m_bot;
    pixel_t m_pix;                          // centre pixel candidate
    logic   win_ok;                         // full 3x3 in this line

    logic signed [GRAD_W-1:0] gx_next;
    logic signed [GRAD_W-1:0] gy_next;

    assign win_ok  = col_de_i && (col_idx_i >= COL_W'(2));
    assign gx_next = $signed({1'b0, wsum(top_luma, mid_luma, bot_luma)})
                   - $signed({1'b0, wsum(l_top, l_mid, l_bot)});    // right minus left
    assign gy_next = $signed({1'b0, wsum(l_bot, m_bot, bot_luma)})
                   - $signed({1'b0, wsum(l_top, m_top, top_luma)}); // bottom minus top

    // column shift, advances on every beat
    always_ff @(posedge clk) begin
        if (col_de_i) begin
            l_top <= m_top;
            l_mid <= m_mid;
            l_bot <= m_bot;
            m_top <= top_luma;
            m_mid <= mid_luma;
            m_bot <= bot_luma;
            m_pix <= mid_pix;
        end
    end

    // ------------------------------
    // stage one, gradients
    // ------------------------------
    logic                     de1_q;
    logic signed [GRAD_W-1:0] gx_q;
    logic signed [GRAD_W-1:0] gy_q;
    pixel_t                   cen_q;        // centre at col_idx-1

    always_ff @(posedge clk) begin
        if (win_ok) begin
            gx_q  <= gx_next;
            gy_q  <= gy_next;
            cen_q <= m_pix;
        end
    end

    // stage two, magnitude and overlay
    logic [GRAD_W-1:0] abs_x;
    logic [GRAD_W-1:0] abs_y;
    logic [GRAD_W:0]   mag_sum;
    luma_t             mag;                 // saturated to 127
    logic              edge_hit;
    pixel_t            grey;

    assign abs_x    = gx_q[GRAD_W-1] ? GRAD_W'(-gx_q) : GRAD_W'(gx_q);
    assign abs_y    = gy_q[GRAD_W-1] ? GRAD_W'(-gy_q) : GRAD_W'(gy_q);
    assign mag_sum  = {1'b0, abs_x} + {1'b0, abs_y};
    assign mag      = (|mag_sum[GRAD_W:LUMA_W]) ? '1 : mag_sum[LUMA_W-1:0];
    assign edge_hit = |mag[LUMA_W-1 -: EDGE_SEL_BITS];
    assign grey     = {mag[LUMA_W-1 -: 5], mag[LUMA_W-1 -: 6], mag[LUMA_W-1 -: 5]};

    always_ff @(posedge clk) begin
        if (de1_q) begin
            pix_o <= edge_hit ? grey : cen_q;   // strong edge goes grey
        end
    end

    // valid pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de1_q    <= 1'b0;
            pix_de_o <= 1'b0;
        end else begin
            de1_q    <= win_ok && !vsync_i;
            pix_de_o <= de1_q && !vsync_i;
        end
    end

endmodule

`default_nettype wire

// File: edge_video_top.sv
`default_nettype none

module edge_video_top import edge_pkg::*; #(
    parameter int LINE_LEN = 480            // active pixels per line
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              vsync_i,     // clears all line/row state
    input  wire logic              cam_href_i,
    input  wire logic [BYTE_W-1:0] cam_data_i,
    output logic                   pix_de_o,
    output pixel_t                 pix_o
);

    localparam int COL_W = $clog2(LINE_LEN);

    // ------------------------------
    // packer to line buffer
    // ------------------------------
    logic   pix_de;
    logic   pix_eol;
    pixel_t pix_data;
    luma_t  pix_luma;

    // line buffer to filter
    logic             col_de;
    logic [LB_W-1:0]  col_top;
    logic [LB_W-1:0]  col_mid;
    logic [LB_W-1:0]  col_bot;
    logic [COL_W-1:0] col_idx;

    cam_byte_packer #(.LINE_LEN(LINE_LEN)) u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync_i    (vsync_i),
        .cam_href_i (cam_href_i),
        .cam_data_i (cam_data_i),
        .pix_de_o   (pix_de),
        .pix_eol_o  (pix_eol),
        .pix_data_o (pix_data),
        .pix_luma_o (pix_luma)
    );

    line_buffer #(.LINE_LEN(LINE_LEN)) u_line_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync_i    (vsync_i),
        .pix_de_i   (pix_de),
        .pix_eol_i  (pix_eol),
        .pix_data_i (pix_data),
        .pix_luma_i (pix_luma),
        .col_de_o   (col_de),
        .col_top_o  (col_top),
        .col_mid_o  (col_mid),
        .col_bot_o  (col_bot),
        .col_idx_o  (col_idx)
    );

    edge_filter3x3 #(.LINE_LEN(LINE_LEN)) u_edge_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync_i    (vsync_i),
        .col_de_i   (col_de),
        .col_top_i  (col_top),
        .col_mid_i  (col_mid),
        .col_bot_i  (col_bot),
        .col_idx_i  (col_idx),
        .pix_de_o   (pix_de_o),
        .pix_o      (pix_o)
    );

endmodule

`default_nettype wire

// File: tb_edge_video.sv
`default_nettype none

module tb_edge_video import edge_pkg::*; ();

    localparam int LINE_LEN   = 8;
    localparam int VEC_DEPTH  = 512;
    localparam int MAX_FRAMES = 16;

    logic              clk;
    logic              rst_n;
    logic              vsync_i;
    logic              cam_href_i;
    logic [BYTE_W-1:0] cam_data_i;
    logic              pix_de_o;
    pixel_t            pix_o;

    logic [PIX_W-1:0] vec_mem [VEC_DEPTH];     // raw vector words
    logic [PIX_W-1:0] exp_q [$];               // results still awaited
    logic [PIX_W-1:0] mon_want;
    int               frame_base [MAX_FRAMES];  // first input pixel of frame
    int               frame_rows [MAX_FRAMES];
    int               frame_cols [MAX_FRAMES];
    int               n_frames;
    int               exp_total;
    int               rx_cnt;
    int               err_data;
    int               err_count;
    int               err_vec;
    int               cycle_cnt;
    int               cycle_limit = 1000000;    // replaced once vectors load
    int unsigned      seed_val;
    logic             head_rows;                // first two rows of a frame

    edge_video_top #(.LINE_LEN(LINE_LEN)) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync_i    (vsync_i),
        .cam_href_i (cam_href_i),
        .cam_data_i (cam_data_i),
        .pix_de_o   (pix_de_o),
        .pix_o      (pix_o)
    );

    always #5 clk = ~clk;

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int luma_of(input logic [PIX_W-1:0] p);
        luma_of = int'(p[15:11]) + int'(p[10:5]) + int'(p[4:0]);   // r + g + b
    endfunction

    // 1-2-1 down one column, centred on row
    function automatic int col_sum(input int base, input int cols, input int row, input int col);
        col_sum = luma_of(vec_mem[base + (row - 1) * cols + col])
                + 2 * luma_of(vec_mem[base + row * cols + col])
                + luma_of(vec_mem[base + (row + 1) * cols + col]);
    endfunction

    // 1-2-1 along one row, centred on col
    function automatic int row_sum(input int base, input int cols, input int row, input int col);
        row_sum = luma_of(vec_mem[base + row * cols + col - 1])
                + 2 * luma_of(vec_mem[base + row * cols + col])
                + luma_of(vec_mem[base + row * cols + col + 1]);
    endfunction

    function automatic logic [PIX_W-1:0] ref_pixel(input int base, input int cols,
                                                   input int row, input int col);
        int         gx;
        int         gy;
        int         sum;
        logic [6:0] mag;
        gx  = col_sum(base, cols, row, col + 1) - col_sum(base, cols, row, col - 1);
        gy  = row_sum(base, cols, row + 1, col) - row_sum(base, cols, row - 1, col);
        sum = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
        mag = (sum > 127) ? 7'd127 : sum[6:0];                   // saturate
        if (mag[6:5] == 2'b00) begin
            ref_pixel = vec_mem[base + row * cols + col];        // weak edge, pass centre
        end else begin
            ref_pixel = {mag[6:2], mag[6:1], mag[6:2]};          // grey level
        end
    endfunction

    // walk the records, check expected pixels against the rule, queue them
    task automatic load_vectors();
        int               ptr;
        int               rows;
        int               cols;
        int               used;
        int               n_exp;
        int               n_rule;
        int               i;
        logic [PIX_W-1:0] want;
        ptr         = 0;
        n_frames    = 0;
        exp_total   = 0;
        cycle_limit = 200;
        while (ptr < VEC_DEPTH - 2 && vec_mem[ptr] != '0 && n_frames < MAX_FRAMES) begin
            rows                 = vec_mem[ptr];
            cols                 = vec_mem[ptr + 1];
            used                 = (cols < LINE_LEN) ? cols : LINE_LEN; // packer truncates
            frame_rows[n_frames] = rows;
            frame_cols[n_frames] = cols;
            frame_base[n_frames] = ptr + 2;
            n_rule = (rows > 2 && used > 2) ? (rows - 2) * (used - 2) : 0;
            ptr    = ptr + 2 + rows * cols;
            n_exp  = vec_mem[ptr];
            if (n_exp != n_rule) begin
                err_vec++;
                $display("vector file: frame %0d lists %0d results, the rule gives %0d",
                         n_frames, n_exp, n_rule);
            end
            for (i = 0; i < n_exp; i++) begin
                exp_q.push_back(vec_mem[ptr + 1 + i]);
                if (n_exp == n_rule) begin
                    want = ref_pixel(frame_base[n_frames], cols,
                                     1 + i / (used - 2), 1 + i % (used - 2));
                    if (want !== vec_mem[ptr + 1 + i]) begin
                        err_vec++;
                        $display("ERR %0t: vector frame %0d result %0d is %h, rule gives %h",
                                 $time, n_frames, i, vec_mem[ptr + 1 + i], want);
                    end
                end
            end
            exp_total   = exp_total + n_exp;
            cycle_limit = cycle_limit + rows * (2 * LINE_LEN + 3 * LINE_LEN + 6);
            ptr         = ptr + 1 + n_exp;
            n_frames++;
        end
        if (n_frames == 0) begin
            err_vec++;
            $display("no frames found in edge_vectors.txt");
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic idle_cycles(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(negedge clk);
            cam_href_i = 1'b0;
            cam_data_i = '0;
        end
    endtask

    // href high means a byte every cycle, so gaps only fit between lines
    task automatic send_line(input int base, input int cols, input int row);
        int               c;
        logic [PIX_W-1:0] p;
        for (c = 0; c < cols; c++) begin
            p = vec_mem[base + row * cols + c];
            @(negedge clk);
            cam_href_i = 1'b1;
            cam_data_i = p[15:8];                // high byte first
            @(negedge clk);
            cam_data_i = p[7:0];
        end
        idle_cycles(1 + ($urandom % 4));         // falling href ends the line
    endtask

    task automatic send_frame(input int f);
        int r;
        head_rows = 1'b1;
        for (r = 0; r < frame_rows[f]; r++) begin
            if (r == 2) begin
                head_rows = 1'b0;
            end
            send_line(frame_base[f], frame_cols[f], r);
        end
        head_rows = 1'b0;
        idle_cycles(6);                          // pipeline drains before vsync
        @(negedge clk);
        vsync_i = 1'b1;
        @(negedge clk);
        vsync_i = 1'b0;
        idle_cycles(1 + ($urandom % 4));
    endtask

    // ------------------------------
    // output monitor and timeout
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n && pix_de_o) begin
            rx_cnt = rx_cnt + 1;
            if (head_rows) begin
                err_count++;
                $display("output beat during the first two rows of a frame at time %0t", $time);
            end
            if (exp_q.size() == 0) begin
                err_count++;
                $display("surplus output beat at time %0t, pixel %h", $time, pix_o);
            end else begin
                mon_want = exp_q.pop_front();
                if (pix_o !== mon_want) begin
                    err_data++;
                    $display("ERR %0t: result %0d expected %h got %h",
                             $time, rx_cnt - 1, mon_want, pix_o);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycle_cnt, rx_cnt, exp_total);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int f;
        clk        = 1'b0;
        rst_n      = 1'b0;
        vsync_i    = 1'b0;
        cam_href_i = 1'b0;
        cam_data_i = '0;
        head_rows  = 1'b0;
        rx_cnt     = 0;
        err_data   = 0;
        err_count  = 0;
        err_vec    = 0;
        cycle_cnt  = 0;
        seed_val   = $urandom(32'h1fb3);
        $readmemh("edge_vectors.txt", vec_mem);
        load_vectors();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(3);
        for (f = 0; f < n_frames; f++) begin
            send_frame(f);
        end
        while (rx_cnt < exp_total) begin
            @(negedge clk);
        end
        idle_cycles(10);                         // window for late surplus beats
        if (rx_cnt != exp_total) begin
            err_count++;
            $display("output count wrong: expected %0d results, received %0d", exp_total, rx_cnt);
        end
        $display("errors: data %0d, count %0d, vectors %0d", err_data, err_count, err_vec);
        if (err_data + err_count + err_vec == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
edge_pkg.sv
cam_byte_packer.sv
line_buffer.sv
edge_filter3x3.sv
edge_video_top.sv
tb_edge_video.sv

// File: Bender.yml
package:
  name: edge_video

sources:
  - edge_pkg.sv
  - cam_byte_packer.sv
  - line_buffer.sv
  - edge_filter3x3.sv
  - edge_video_top.sv
  - target: test
    files:
      - tb_edge_video.sv

// File: edge_vectors.txt
// record: rows cols, then rows x cols rgb565 input pixels, one line per row,
// then the result count and the expected output pixels; rows of 0000 ends the file
0003 0008   // flat frame
8410 8410 8410 8410 8410 8410 8410 8410
8410 8410 8410 8410 8410 8410 8410 8410
8410 8410 8410 8410 8410 8410 8410 8410
0006 8410 8410 8410 8410 8410 8410
0003 0008   // vertical step, luma 0 to 125
0000 0000 0000 0000 FFFF FFFF FFFF FFFF
0000 0000 0000 0000 FFFF FFFF FFFF FFFF
0000 0000 0000 0000 FFFF FFFF FFFF FFFF
0006 0000 0000 FFFF FFFF FFFF FFFF
0005 0008   // constant luma 30, r = row, b = column
03C0 03A1 0382 0363 0344 0325 0306 02E7
0BA0 0B81 0B62 0B43 0B24 0B05 0AE6 0AC7
1380 1361 1342 1323 1304 12E5 12C6 12A7
1B60 1B41 1B22 1B03 1AE4 1AC5 1AA6 1A87
2340 2321 2302 22E3 22C4 22A5 2286 2267
0012 0B81 0B62 0B43 0B24 0B05 0AE6
1361 1342 1323 1304 12E5 12C6
1B41 1B22 1B03 1AE4 1AC5 1AA6
0003 000A   // long lines, last two pixels dropped
03C0 03A1 0382 0363 0344 0325 0306 02E7 FFFF 0000
0BA0 0B81 0B62 0B43 0B24 0B05 0AE6 0AC7 FFFF 0000
1380 1361 1342 1323 1304 12E5 12C6 12A7 FFFF 0000
0006 0B81 0B62 0B43 0B24 0B05 0AE6
0002 0008   // partial frame, cut by vsync
8410 8410 8410 8410 8410 8410 8410 8410
8410 8410 8410 8410 8410 8410 8410 8410
0000
0004 0008   // horizontal step, luma 10 down to 0
0140 0140 0140 0140 0140 0140 0140 0140
0140 0140 0140 0140 0140 0140 0140 0140
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
000C 528A 528A 528A 528A 528A 528A
528A 528A 528A 528A 528A 528A
0000
